/* common/exec_pkg.sv */
/*
 * Widths, unit and micro-op encodings, and the stage structs.
 * fu is one-hot. A CFU uop with bits [4:3] == 2'b00 is a conditional branch.
 * LSU uops carry load and store as flag bits, not as codes.
 */
package exec_pkg;

    localparam int XLEN      = 32;  // Data width
    localparam int MUL_STEPS = 32;  // One iteration per multiplier bit

    typedef logic [XLEN-1:0] ex_word_t;
    typedef logic [4:0]      ex_fu_t;
    typedef logic [4:0]      ex_uop_t;

    // Functional unit bit positions ------------------
    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_LSU = 2;
    localparam int FU_CFU = 3;
    localparam int FU_CSR = 4;

    // ALU micro-ops ----------------------------------
    localparam ex_uop_t ALU_ADD  = 5'd0;
    localparam ex_uop_t ALU_SUB  = 5'd1;
    localparam ex_uop_t ALU_XOR  = 5'd2;
    localparam ex_uop_t ALU_OR   = 5'd3;
    localparam ex_uop_t ALU_AND  = 5'd4;
    localparam ex_uop_t ALU_SLL  = 5'd5;
    localparam ex_uop_t ALU_SRL  = 5'd6;
    localparam ex_uop_t ALU_SRA  = 5'd7;
    localparam ex_uop_t ALU_SLT  = 5'd8;
    localparam ex_uop_t ALU_SLTU = 5'd9;

    localparam ex_uop_t MUL_MUL    = 5'd0;  // Low word
    localparam ex_uop_t MUL_MULH   = 5'd1;  // High word, signed x signed
    localparam ex_uop_t MUL_MULHSU = 5'd2;  // High word, signed x unsigned
    localparam ex_uop_t MUL_MULHU  = 5'd3;  // High word, unsigned x unsigned

    // Control flow micro-ops -------------------------
    localparam ex_uop_t CFU_BEQ       = 5'b00_001;
    localparam ex_uop_t CFU_BNE       = 5'b00_010;
    localparam ex_uop_t CFU_BLT       = 5'b00_011;
    localparam ex_uop_t CFU_BGE       = 5'b00_100;
    localparam ex_uop_t CFU_BLTU      = 5'b00_101;
    localparam ex_uop_t CFU_BGEU      = 5'b00_110;
    localparam ex_uop_t CFU_JALI      = 5'b10_010;
    localparam ex_uop_t CFU_JALR      = 5'b10_100;
    localparam ex_uop_t CFU_TAKEN     = 5'b11_000;  // Resolved branch, taken
    localparam ex_uop_t CFU_NOT_TAKEN = 5'b11_001;  // Resolved branch, fall through

    localparam int LSU_LOAD_BIT  = 3;   // Set in every load uop
    localparam int LSU_STORE_BIT = 4;   // Set in every store uop

    // Instruction entering execute
    typedef struct packed {
        logic [4:0] rd;         // Destination register
        ex_word_t   opr_a;      // rs1 or PC
        ex_word_t   opr_b;      // rs2 or immediate
        ex_word_t   opr_c;      // Store data, CSR data or branch target
        ex_uop_t    uop;
        ex_fu_t     fu;
        logic       trap;       // Raised earlier, passed on
        logic [1:0] size;       // Instruction size
        logic [31:0] instr;     // Instruction word
    } ex_in_t;

    // Control fields towards writeback
    typedef struct packed {
        logic [4:0]  rd;
        ex_uop_t     uop;       // Branches rewritten to taken/not taken
        ex_fu_t      fu;
        logic        trap;
        logic [1:0]  size;
        logic [31:0] instr;
    } ex_ctrl_t;

    // Forwarding from the instruction in execute
    typedef struct packed {
        logic [4:0] rd;
        ex_word_t   wdata;      // Stage result, not valid for loads
        logic       load;       // Result comes from memory later
        logic       csr;        // Result comes from CSR file later
    } ex_fwd_t;

endpackage

/* filelist.f */
+incdir+verification
common/exec_pkg.sv
verilog/exec_alu.sv
multiplier/exec_mul.sv
verilog/exec_result_select.sv
verilog/exec_pipe_reg.sv
verilog/exec_stage.sv
verification/tb_exec_stage.sv

/* multiplier/exec_mul.sv */
`timescale 1ns/1ps
/*
 * Iterative shift-add multiplier on operand magnitudes, one bit per cycle.
 * STEPS must equal XLEN. Operands and signs are sampled at start only.
 * The product holds with o_ready high until i_clear returns the unit to idle.
 */
module exec_mul #(
    parameter int STEPS = 32                // Shift-add iterations
) (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  logic               i_valid,     // Multiply op waiting in stage
    input  logic               i_clear,     // Pipe progress or flush
    input  exec_pkg::ex_uop_t  i_uop,       // Selects operand signedness
    input  exec_pkg::ex_word_t i_rs1,
    input  exec_pkg::ex_word_t i_rs2,
    output logic               o_ready,     // Product available
    output exec_pkg::ex_word_t o_result_hi,
    output exec_pkg::ex_word_t o_result_lo
);

    localparam int XL = exec_pkg::XLEN;
    localparam int CW = $clog2(STEPS);

    logic               a_signed;
    logic               b_signed;
    logic               a_neg;
    logic               b_neg;
    exec_pkg::ex_word_t a_mag;
    exec_pkg::ex_word_t b_mag;
    logic               start;
    logic               running;
    logic [CW-1:0]      count;
    logic               negate;
    exec_pkg::ex_word_t mcand;
    logic [2*XL-1:0]    acc;
    logic [XL:0]        partial;
    logic [2*XL-1:0]    product;

    // mul keeps the low word, same for any signedness
    assign a_signed = (i_uop != exec_pkg::MUL_MULHU);
    assign b_signed = (i_uop == exec_pkg::MUL_MUL) || (i_uop == exec_pkg::MUL_MULH);
    assign a_neg    = a_signed && i_rs1[XL-1];
    assign b_neg    = b_signed && i_rs2[XL-1];
    assign a_mag    = a_neg ? -i_rs1 : i_rs1;
    assign b_mag    = b_neg ? -i_rs2 : i_rs2;
    assign start    = i_valid && !running && !o_ready && !i_clear;

    // Upper half plus multiplicand when the current multiplier bit is set
    assign partial = {1'b0, acc[2*XL-1:XL]} + (acc[0] ? {1'b0, mcand} : {(XL+1){1'b0}});

    // Control ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_clear) begin
            running <= 1'b0;
            o_ready <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            count   <= '0;
        end else if (running) begin
            count <= count + 1'b1;
            if (count == CW'(STEPS-1)) begin    // Last step this cycle
                running <= 1'b0;
                o_ready <= 1'b1;
            end
        end
    end

    // Datapath ---------------------------------------
    always_ff @(posedge g_clk) begin
        if (start) begin
            acc    <= {{XL{1'b0}}, b_mag};      // Multiplier in low half
            mcand  <= a_mag;
            negate <= a_neg ^ b_neg;
        end else if (running) begin
            acc <= {partial, acc[XL-1:1]};      // Add then shift right
        end
    end

    assign product     = negate ? -acc : acc;   // Sign fix-up
    assign o_result_hi = product[2*XL-1:XL];
    assign o_result_lo = product[XL-1:0];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and judge the log
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_stage \
    -f filelist.f -o sim_exec > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_exec > "$LOG" 2>&1
cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" "$LOG" || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

/* verification/exec_ref.svh */
/*
 * Expected execute results, worked out from the ISA rules.
 * opr_b is only checked for stores and CSR ops. Other ops leave that register untouched.
 * Meant to be included inside the testbench module.
 */
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

typedef struct packed {
    exec_pkg::ex_ctrl_t ctrl;       // Stage-3 control fields
    exec_pkg::ex_word_t opr_a;      // Result, address or target
    exec_pkg::ex_word_t opr_b;      // Store or CSR data
    logic               chk_b;      // opr_b is meaningful
    exec_pkg::ex_fwd_t  fwd;        // Forwarding while in stage 2
} exp_t;

function automatic exp_t ref_execute(input exec_pkg::ex_in_t s);
    exp_t        e;
    logic [31:0] sum;
    logic [63:0] a_sx;
    logic [63:0] b_sx;
    logic [63:0] a_zx;
    logic [63:0] b_zx;
    logic [63:0] prod;
    logic        taken;
    e    = '0;
    sum  = s.opr_a + s.opr_b;
    a_sx = {{32{s.opr_a[31]}}, s.opr_a};        // Sign extended
    b_sx = {{32{s.opr_b[31]}}, s.opr_b};
    a_zx = {32'b0, s.opr_a};                    // Zero extended
    b_zx = {32'b0, s.opr_b};
    e.ctrl.rd    = s.rd;
    e.ctrl.uop   = s.uop;
    e.ctrl.fu    = s.fu;
    e.ctrl.trap  = s.trap;
    e.ctrl.size  = s.size;
    e.ctrl.instr = s.instr;
    if (s.fu[exec_pkg::FU_ALU]) begin
        case (s.uop)
            exec_pkg::ALU_ADD:  e.opr_a = sum;
            exec_pkg::ALU_SUB:  e.opr_a = s.opr_a - s.opr_b;
            exec_pkg::ALU_XOR:  e.opr_a = s.opr_a ^ s.opr_b;
            exec_pkg::ALU_OR:   e.opr_a = s.opr_a | s.opr_b;
            exec_pkg::ALU_AND:  e.opr_a = s.opr_a & s.opr_b;
            exec_pkg::ALU_SLL:  e.opr_a = s.opr_a << s.opr_b[4:0];
            exec_pkg::ALU_SRL:  e.opr_a = s.opr_a >> s.opr_b[4:0];
            exec_pkg::ALU_SRA:  e.opr_a = $signed(s.opr_a) >>> s.opr_b[4:0];
            exec_pkg::ALU_SLT:  e.opr_a = {31'b0, $signed(s.opr_a) < $signed(s.opr_b)};
            exec_pkg::ALU_SLTU: e.opr_a = {31'b0, s.opr_a < s.opr_b};
            default:            e.opr_a = '0;
        endcase
    end else if (s.fu[exec_pkg::FU_MUL]) begin
        case (s.uop)
            exec_pkg::MUL_MUL,
            exec_pkg::MUL_MULH:   prod = a_sx * b_sx;
            exec_pkg::MUL_MULHSU: prod = a_sx * b_zx;
            default:              prod = a_zx * b_zx;
        endcase
        e.opr_a = (s.uop == exec_pkg::MUL_MUL) ? prod[31:0] : prod[63:32];
    end else if (s.fu[exec_pkg::FU_LSU]) begin
        e.opr_a = sum;                              // Memory address
        e.chk_b = s.uop[exec_pkg::LSU_STORE_BIT];
        e.opr_b = e.chk_b ? s.opr_c : '0;
    end else if (s.fu[exec_pkg::FU_CFU]) begin
        if (s.uop[4:3] == 2'b00) begin
            case (s.uop)
                exec_pkg::CFU_BEQ:  taken = (s.opr_a == s.opr_b);
                exec_pkg::CFU_BNE:  taken = (s.opr_a != s.opr_b);
                exec_pkg::CFU_BLT:  taken = $signed(s.opr_a) < $signed(s.opr_b);
                exec_pkg::CFU_BGE:  taken = $signed(s.opr_a) >= $signed(s.opr_b);
                exec_pkg::CFU_BLTU: taken = s.opr_a < s.opr_b;
                default:            taken = s.opr_a >= s.opr_b;
            endcase
            e.ctrl.uop = taken ? exec_pkg::CFU_TAKEN : exec_pkg::CFU_NOT_TAKEN;
        end
        e.opr_a = (s.uop == exec_pkg::CFU_JALR) ? {sum[31:1], 1'b0} : {s.opr_c[31:1], 1'b0};
    end else if (s.fu[exec_pkg::FU_CSR]) begin
        e.opr_a = s.opr_a;
        e.opr_b = s.opr_c;
        e.chk_b = 1'b1;
    end
    e.fwd.rd    = s.rd;
    e.fwd.wdata = e.opr_a;
    e.fwd.load  = s.fu[exec_pkg::FU_LSU] && s.uop[exec_pkg::LSU_LOAD_BIT];
    e.fwd.csr   = s.fu[exec_pkg::FU_CSR];
    return e;
endfunction

`endif

/* verification/tb_exec_stage.sv */
`timescale 1ns/1ps
/*
 * Random execute-stage test with writeback back-pressure and periodic flushes.
 * Flushes are only issued while no instruction is offered to stage 2.
 * Needs a simulator with timing support.
 */
module tb_exec_stage;

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_TXN      = 300;
    localparam int FLUSH_EVERY  = 25;
    localparam int STALL_FACTOR = 4;       // Writeback is busy one cycle in four
    localparam int WATCHDOG_NS  =
        (NUM_TXN * (exec_pkg::MUL_STEPS + 4) * STALL_FACTOR + 2000) * CLK_PERIOD;

    logic               g_clk = 1'b0;
    logic               g_resetn;
    exec_pkg::ex_in_t   i_s2;
    logic               i_s2_valid;
    logic               o_s2_busy;
    logic               i_flush;
    exec_pkg::ex_fwd_t  o_fwd;
    exec_pkg::ex_ctrl_t o_s3_ctrl;
    exec_pkg::ex_word_t o_s3_opr_a;
    exec_pkg::ex_word_t o_s3_opr_b;
    logic               o_s3_valid;
    logic               i_s3_busy;

    `include "exec_ref.svh"

    logic [31:0]        lfsr = 32'hd5b2;
    exp_t               exp_q[$];           // Accepted and not yet delivered
    int                 err_cnt   = 0;      // Wrong values
    int                 flow_cnt  = 0;      // Ordering and handshake faults
    int                 check_cnt = 0;
    int                 flushed   = 0;
    logic               hold_pend = 1'b0;
    exec_pkg::ex_ctrl_t hold_ctrl;
    exec_pkg::ex_word_t hold_opr_a;

    exec_stage #(.MUL_STEPS(exec_pkg::MUL_STEPS)) dut0 (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .i_s2 (i_s2), .i_s2_valid (i_s2_valid), .o_s2_busy (o_s2_busy),
        .i_flush (i_flush), .o_fwd (o_fwd),
        .o_s3_ctrl (o_s3_ctrl), .o_s3_opr_a (o_s3_opr_a), .o_s3_opr_b (o_s3_opr_b),
        .o_s3_valid (o_s3_valid), .i_s3_busy (i_s3_busy)
    );

    initial begin
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // Stimulus helpers ---------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // Galois step
        end
        return v;
    endfunction

    function automatic exec_pkg::ex_word_t edge_word();
        case (rand_bits(2))
            0:       return '0;
            1:       return '1;                 // Minus one
            2:       return 32'h8000_0000;      // Most negative
            default: return rand_bits(32);
        endcase
    endfunction

    function automatic exec_pkg::ex_in_t gen_instr();
        exec_pkg::ex_in_t s;
        logic [31:0]      sel;
        s       = '0;
        sel     = rand_bits(3);
        s.rd    = 5'(rand_bits(5));
        s.opr_a = rand_bits(32);
        s.opr_b = rand_bits(32);
        if (rand_bits(2) == 0) s.opr_b = s.opr_a;   // Equal operands for beq/bge
        s.opr_c = rand_bits(32);
        s.trap  = (rand_bits(3) == 0);
        s.size  = 2'(rand_bits(2));
        s.instr = rand_bits(32);
        if (sel < 3) begin
            s.fu[exec_pkg::FU_ALU] = 1'b1;
            s.uop = 5'(rand_bits(4) % 10);
        end else if (sel == 3) begin
            s.fu[exec_pkg::FU_MUL] = 1'b1;
            s.uop = 5'(rand_bits(2));
            if (rand_bits(1) != 0) s.opr_a = edge_word();
            if (rand_bits(1) != 0) s.opr_b = edge_word();
        end else if (sel == 4) begin
            s.fu[exec_pkg::FU_LSU] = 1'b1;
            s.uop = 5'(rand_bits(3));                 // Access width bits
            if (rand_bits(1) != 0) s.uop[exec_pkg::LSU_STORE_BIT] = 1'b1;
            else s.uop[exec_pkg::LSU_LOAD_BIT] = 1'b1;
        end else if (sel < 7) begin
            s.fu[exec_pkg::FU_CFU] = 1'b1;
            case (rand_bits(3))
                0:       s.uop = exec_pkg::CFU_BEQ;
                1:       s.uop = exec_pkg::CFU_BNE;
                2:       s.uop = exec_pkg::CFU_BLT;
                3:       s.uop = exec_pkg::CFU_BGE;
                4:       s.uop = exec_pkg::CFU_BLTU;
                5:       s.uop = exec_pkg::CFU_BGEU;
                6:       s.uop = exec_pkg::CFU_JALI;
                default: s.uop = exec_pkg::CFU_JALR;
            endcase
        end else begin
            s.fu[exec_pkg::FU_CSR] = 1'b1;
            s.uop = 5'(rand_bits(5));
        end
        return s;
    endfunction

    // Offer one instruction until stage 2 takes it; called at a falling edge
    task automatic send_instr(input exec_pkg::ex_in_t s);
        exp_t e;
        int   waits;
        logic accepted;
        e          = ref_execute(s);
        waits      = 0;
        accepted   = 1'b0;
        i_s2       = s;
        i_s2_valid = 1'b1;
        while (!accepted) begin
            i_s3_busy = (rand_bits(2) == 0);
            @(posedge g_clk);
            if (o_s2_busy) begin
                waits++;
            end else begin
                accepted = 1'b1;
                exp_q.push_back(e);
                assert (o_fwd == e.fwd) else begin
                    err_cnt++;
                    $display("ERR %0t: fwd %h, expected %h", $time, o_fwd, e.fwd);
                end
                if (s.fu[exec_pkg::FU_MUL]) begin
                    assert (waits > exec_pkg::MUL_STEPS) else begin
                        flow_cnt++;
                        $display("Multiply was accepted after only %0d stall cycles", waits);
                    end
                end
            end
            @(negedge g_clk);
        end
        assert (o_s3_valid) else begin
            flow_cnt++;
            $display("Stage 3 not valid one cycle after acceptance, at %0t", $time);
        end
        i_s2_valid = 1'b0;
    endtask

    task automatic flush_stage();
        i_s2_valid = 1'b0;
        i_s3_busy  = 1'b1;          // Nothing leaves stage 3 this cycle
        i_flush    = 1'b1;
        @(posedge g_clk);
        if (o_s3_valid) begin
            exp_q.delete(0);        // Dropped by the flush
            flushed++;
        end
        @(negedge g_clk);
        i_flush = 1'b0;
        assert (!o_s3_valid && exp_q.size() == 0) else begin
            flow_cnt++;
            $display("Flush did not empty stage 3 at %0t", $time);
        end
    endtask

    // Scoreboard ---------------------------------------
    always @(posedge g_clk) begin
        exp_t e;
        if (hold_pend) begin
            assert (o_s3_valid && o_s3_ctrl == hold_ctrl && o_s3_opr_a == hold_opr_a) else begin
                flow_cnt++;
                $display("Stage 3 changed while writeback was busy, at %0t", $time);
            end
        end
        hold_pend  = g_resetn && !i_flush && o_s3_valid && i_s3_busy;
        hold_ctrl  = o_s3_ctrl;
        hold_opr_a = o_s3_opr_a;
        if (g_resetn && o_s3_valid && !i_s3_busy) begin
            assert (exp_q.size() != 0) else begin
                flow_cnt++;
                $display("Stage 3 delivered a result nobody sent, at %0t", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_cnt++;
                assert (o_s3_ctrl == e.ctrl) else begin
                    err_cnt++;
                    $display("ERR %0t: ctrl %h, expected %h", $time, o_s3_ctrl, e.ctrl);
                end
                assert (o_s3_opr_a == e.opr_a) else begin
                    err_cnt++;
                    $display("ERR %0t: opr_a %h, expected %h", $time, o_s3_opr_a, e.opr_a);
                end
                assert (!e.chk_b || o_s3_opr_b == e.opr_b) else begin
                    err_cnt++;
                    $display("ERR %0t: opr_b %h, expected %h", $time, o_s3_opr_b, e.opr_b);
                end
            end
        end
    end

    // Main sequence ------------------------------------
    initial begin
        g_resetn   = 1'b0;
        i_s2       = '0;
        i_s2_valid = 1'b0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b1;          // Writeback refuses, so busy reflects stage 3
        repeat (2) @(negedge g_clk);
        g_resetn = 1'b1;
        assert (!o_s3_valid && !o_s2_busy) else begin
            flow_cnt++;
            $display("Stage not idle after reset");
        end
        for (int n = 0; n < NUM_TXN; n++) begin
            send_instr(gen_instr());
            if (n % FLUSH_EVERY == FLUSH_EVERY - 1) flush_stage();
        end
        i_s3_busy = 1'b0;           // Drain
        while (exp_q.size() != 0) @(negedge g_clk);
        repeat (2) @(negedge g_clk);
        assert (!o_s3_valid) else begin
            flow_cnt++;
            $display("Stage 3 still valid after the drain");
        end
        $display("Checks %0d, value errors %0d, other errors %0d, flushed %0d",
                 check_cnt, err_cnt, flow_cnt, flushed);
        if (err_cnt == 0 && flow_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the stage stopped making progress");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* verilog/exec_alu.sv */
`timescale 1ns/1ps
/*
 * Combinational integer ALU. One adder serves add, sub and compares.
 * i_cmp_force turns the adder into a compare for branches, so o_add_result
 * then holds the difference. o_result is zero unless i_is_alu is set.
 */
module exec_alu (
    input  exec_pkg::ex_uop_t  i_uop,           // Micro-op code
    input  logic               i_is_alu,        // ALU op in stage
    input  logic               i_cmp_unsigned,  // bltu / bgeu
    input  logic               i_cmp_force,     // Conditional branch
    input  exec_pkg::ex_word_t i_lhs,           // Left operand
    input  exec_pkg::ex_word_t i_rhs,           // Right operand
    output exec_pkg::ex_word_t o_result,        // ALU result
    output exec_pkg::ex_word_t o_add_result,    // Raw adder output
    output logic               o_lt,            // LHS < RHS
    output logic               o_eq             // LHS == RHS
);

    localparam int XL = exec_pkg::XLEN;

    logic        op_sub;
    logic        op_slt;
    logic        op_sltu;
    logic        do_sub;
    logic        cmp_unsigned;
    logic        lhs_ext;
    logic        rhs_ext;
    logic [XL:0] rhs_opnd;
    logic [XL:0] sum;
    logic [4:0]  shamt;

    assign op_sub  = i_is_alu && (i_uop == exec_pkg::ALU_SUB);
    assign op_slt  = i_is_alu && (i_uop == exec_pkg::ALU_SLT);
    assign op_sltu = i_is_alu && (i_uop == exec_pkg::ALU_SLTU);

    assign do_sub       = op_sub || op_slt || op_sltu || i_cmp_force;
    assign cmp_unsigned = op_sltu || i_cmp_unsigned;

    // Extra top bit makes the sign of the difference the compare result
    assign lhs_ext  = !cmp_unsigned && i_lhs[XL-1];         // Sign or zero extend
    assign rhs_ext  = !cmp_unsigned && i_rhs[XL-1];
    assign rhs_opnd = {rhs_ext, i_rhs} ^ {(XL+1){do_sub}};  // Invert for subtract
    assign sum      = {lhs_ext, i_lhs} + rhs_opnd + {{XL{1'b0}}, do_sub};

    assign o_add_result = sum[XL-1:0];
    assign o_lt         = sum[XL];                          // Negative difference
    assign o_eq         = (i_lhs == i_rhs);
    assign shamt        = i_rhs[4:0];                       // Low 5 bits only

    always_comb begin
        o_result = '0;
        if (i_is_alu) begin
            case (i_uop)
                exec_pkg::ALU_ADD,
                exec_pkg::ALU_SUB:  o_result = sum[XL-1:0];
                exec_pkg::ALU_XOR:  o_result = i_lhs ^ i_rhs;
                exec_pkg::ALU_OR:   o_result = i_lhs | i_rhs;
                exec_pkg::ALU_AND:  o_result = i_lhs & i_rhs;
                exec_pkg::ALU_SLL:  o_result = i_lhs << shamt;
                exec_pkg::ALU_SRL:  o_result = i_lhs >> shamt;
                exec_pkg::ALU_SRA:  o_result = $signed(i_lhs) >>> shamt;
                exec_pkg::ALU_SLT,
                exec_pkg::ALU_SLTU: o_result = {{(XL-1){1'b0}}, o_lt};
                default:            o_result = '0;
            endcase
        end
    end

endmodule

/* verilog/exec_pipe_reg.sv */
`timescale 1ns/1ps
/*
 * Single-entry valid/busy pipeline register, no skid buffer.
 * o_busy is high while a held item is refused downstream. Flush clears both
 * valid and data.
 */
module exec_pipe_reg #(
    parameter type T_PAYLOAD = logic [31:0]     // Held item
) (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     i_flush,   // Drop held item
    input  T_PAYLOAD i_data,
    input  logic     i_valid,   // Upstream offers data
    output logic     o_busy,    // Upstream must hold
    output T_PAYLOAD o_data,
    output logic     o_valid,
    input  logic     i_busy     // Downstream refuses
);

    logic load;

    assign o_busy = o_valid && i_busy;
    assign load   = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;    // Taken downstream, nothing new
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_flush) begin
            o_data <= '0;
        end else if (load) begin
            o_data <= i_data;
        end
    end

endmodule

/* verilog/exec_result_select.sv */
`timescale 1ns/1ps
/*
 * Unit decode, branch resolution and next stage-3 value selection.
 * fu must be one-hot; opr_a is an AND-OR mux over the unit bits.
 */
module exec_result_select (
    input  exec_pkg::ex_in_t   i_s2,            // Instruction in stage
    input  exec_pkg::ex_word_t i_alu_result,
    input  exec_pkg::ex_word_t i_add_result,    // Address / jalr sum
    input  exec_pkg::ex_word_t i_mul_result,    // Selected product word
    input  logic               i_lt,
    input  logic               i_eq,
    input  logic               i_s2_accept,     // Transfer into stage 3
    output logic               o_cmp_unsigned,
    output logic               o_cmp_force,
    output logic               o_is_alu,
    output logic               o_is_mul,
    output exec_pkg::ex_ctrl_t o_ctrl,
    output exec_pkg::ex_word_t o_opr_a,
    output exec_pkg::ex_word_t o_opr_b,
    output logic               o_opr_a_en,
    output logic               o_opr_b_en,
    output exec_pkg::ex_fwd_t  o_fwd
);

    localparam int XL = exec_pkg::XLEN;

    logic               fu_lsu;
    logic               fu_cfu;
    logic               fu_csr;
    logic               cfu_cond;
    logic               cfu_jalr;
    logic               taken;
    logic               lsu_load;
    logic               lsu_store;
    exec_pkg::ex_word_t target;

    assign o_is_alu = i_s2.fu[exec_pkg::FU_ALU];
    assign o_is_mul = i_s2.fu[exec_pkg::FU_MUL];
    assign fu_lsu   = i_s2.fu[exec_pkg::FU_LSU];
    assign fu_cfu   = i_s2.fu[exec_pkg::FU_CFU];
    assign fu_csr   = i_s2.fu[exec_pkg::FU_CSR];

    assign lsu_load  = fu_lsu && i_s2.uop[exec_pkg::LSU_LOAD_BIT];
    assign lsu_store = fu_lsu && i_s2.uop[exec_pkg::LSU_STORE_BIT];

    // Branch resolution ------------------------------
    assign cfu_cond       = fu_cfu && (i_s2.uop[4:3] == 2'b00);
    assign cfu_jalr       = fu_cfu && (i_s2.uop == exec_pkg::CFU_JALR);
    assign o_cmp_force    = cfu_cond;
    assign o_cmp_unsigned = fu_cfu && (i_s2.uop == exec_pkg::CFU_BLTU ||
                                       i_s2.uop == exec_pkg::CFU_BGEU);

    always_comb begin
        case (i_s2.uop)
            exec_pkg::CFU_BEQ:  taken = i_eq;
            exec_pkg::CFU_BNE:  taken = !i_eq;
            exec_pkg::CFU_BLT,
            exec_pkg::CFU_BLTU: taken = i_lt;   // Signedness set in the ALU
            exec_pkg::CFU_BGE,
            exec_pkg::CFU_BGEU: taken = !i_lt;
            default:            taken = 1'b0;
        endcase
    end

    assign target = cfu_jalr ? {i_add_result[XL-1:1], 1'b0} : {i_s2.opr_c[XL-1:1], 1'b0};

    // Stage-3 values ---------------------------------
    assign o_opr_a = ({XL{o_is_alu}} & i_alu_result) |
                     ({XL{o_is_mul}} & i_mul_result) |
                     ({XL{fu_lsu}}   & i_add_result) |  // Memory address
                     ({XL{fu_cfu}}   & target)       |
                     ({XL{fu_csr}}   & i_s2.opr_a);
    assign o_opr_b = (lsu_store || fu_csr) ? i_s2.opr_c : '0;  // Store / CSR data

    assign o_opr_a_en = i_s2_accept;
    assign o_opr_b_en = i_s2_accept && (lsu_store || fu_csr);

    assign o_ctrl.rd    = i_s2.rd;
    assign o_ctrl.uop   = cfu_cond ? (taken ? exec_pkg::CFU_TAKEN : exec_pkg::CFU_NOT_TAKEN)
                                   : i_s2.uop;
    assign o_ctrl.fu    = i_s2.fu;
    assign o_ctrl.trap  = i_s2.trap;    // Passed through untouched
    assign o_ctrl.size  = i_s2.size;
    assign o_ctrl.instr = i_s2.instr;

    assign o_fwd.rd    = i_s2.rd;
    assign o_fwd.wdata = o_opr_a;
    assign o_fwd.load  = lsu_load;
    assign o_fwd.csr   = fu_csr;

endmodule

/* verilog/exec_stage.sv */
`timescale 1ns/1ps
/*
 * Execute stage: ALU, branch compare, address generation, CSR pass-through
 * and an iterative multiplier that stalls stage 2 while it runs.
 * o_fwd follows the current stage-2 input combinationally.
 */
module exec_stage #(
    parameter int MUL_STEPS = exec_pkg::MUL_STEPS   // Multiplier iterations
) (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  exec_pkg::ex_in_t   i_s2,        // From decode
    input  logic               i_s2_valid,
    output logic               o_s2_busy,
    input  logic               i_flush,     // Drop stage 3 and the multiply
    output exec_pkg::ex_fwd_t  o_fwd,
    output exec_pkg::ex_ctrl_t o_s3_ctrl,   // To writeback
    output exec_pkg::ex_word_t o_s3_opr_a,
    output exec_pkg::ex_word_t o_s3_opr_b,
    output logic               o_s3_valid,
    input  logic               i_s3_busy
);

    exec_pkg::ex_ctrl_t n_ctrl;
    exec_pkg::ex_word_t n_opr_a;
    exec_pkg::ex_word_t n_opr_b;
    exec_pkg::ex_word_t alu_result;
    exec_pkg::ex_word_t add_result;
    exec_pkg::ex_word_t mul_hi;
    exec_pkg::ex_word_t mul_lo;
    exec_pkg::ex_word_t mul_result;
    logic               opr_a_en;
    logic               opr_b_en;
    logic               is_alu;
    logic               is_mul;
    logic               cmp_unsigned;
    logic               cmp_force;
    logic               alu_lt;
    logic               alu_eq;
    logic               mul_ready;
    logic               ctrl_busy;
    logic               pipe_progress;

    // Stall control ----------------------------------
    assign pipe_progress = i_s2_valid && !o_s2_busy;
    assign o_s2_busy     = ctrl_busy || (i_s2_valid && is_mul && !mul_ready);
    assign mul_result    = (i_s2.uop == exec_pkg::MUL_MUL) ? mul_lo : mul_hi;

    exec_alu u_alu (
        .i_uop          (i_s2.uop),
        .i_is_alu       (is_alu),
        .i_cmp_unsigned (cmp_unsigned),
        .i_cmp_force    (cmp_force),
        .i_lhs          (i_s2.opr_a),
        .i_rhs          (i_s2.opr_b),
        .o_result       (alu_result),
        .o_add_result   (add_result),
        .o_lt           (alu_lt),
        .o_eq           (alu_eq)
    );

    exec_mul #(.STEPS(MUL_STEPS)) u_mul (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_valid     (i_s2_valid && is_mul),
        .i_clear     (pipe_progress || i_flush),    // Back to idle
        .i_uop       (i_s2.uop),
        .i_rs1       (i_s2.opr_a),
        .i_rs2       (i_s2.opr_b),
        .o_ready     (mul_ready),
        .o_result_hi (mul_hi),
        .o_result_lo (mul_lo)
    );

    exec_result_select u_sel (
        .i_s2           (i_s2),
        .i_alu_result   (alu_result),
        .i_add_result   (add_result),
        .i_mul_result   (mul_result),
        .i_lt           (alu_lt),
        .i_eq           (alu_eq),
        .i_s2_accept    (pipe_progress),
        .o_cmp_unsigned (cmp_unsigned),
        .o_cmp_force    (cmp_force),
        .o_is_alu       (is_alu),
        .o_is_mul       (is_mul),
        .o_ctrl         (n_ctrl),
        .o_opr_a        (n_opr_a),
        .o_opr_b        (n_opr_b),
        .o_opr_a_en     (opr_a_en),
        .o_opr_b_en     (opr_b_en),
        .o_fwd          (o_fwd)
    );

    // Stage-3 registers ------------------------------
    exec_pipe_reg #(.T_PAYLOAD(exec_pkg::ex_ctrl_t)) ctrl_reg (
        .g_clk (g_clk), .g_resetn (g_resetn), .i_flush (i_flush),
        .i_data (n_ctrl), .i_valid (pipe_progress), .o_busy (ctrl_busy),
        .o_data (o_s3_ctrl), .o_valid (o_s3_valid), .i_busy (i_s3_busy)
    );

    // Operand registers follow the control register, handshake unused
    exec_pipe_reg #(.T_PAYLOAD(exec_pkg::ex_word_t)) opr_a_reg (
        .g_clk (g_clk), .g_resetn (g_resetn), .i_flush (i_flush),
        .i_data (n_opr_a), .i_valid (opr_a_en), .o_busy (),
        .o_data (o_s3_opr_a), .o_valid (), .i_busy (i_s3_busy)
    );

    exec_pipe_reg #(.T_PAYLOAD(exec_pkg::ex_word_t)) opr_b_reg (
        .g_clk (g_clk), .g_resetn (g_resetn), .i_flush (i_flush),
        .i_data (n_opr_b), .i_valid (opr_b_en), .o_busy (),
        .o_data (o_s3_opr_b), .o_valid (), .i_busy (i_s3_busy)
    );

endmodule
